// ==== branch_resolve.sv ====
// One resolve lane, purely combinational; fall-through is always pc+4
`timescale 1ns/100ps

module branch_resolve (
	input  logic                        valid_i,
	input  logic [bru_pkg::XLEN-1:0]    pc_i,
	input  logic [bru_pkg::XLEN-1:0]    rj_i,
	input  logic [bru_pkg::XLEN-1:0]    rd_i,
	input  bru_pkg::br_kind_t           kind_i,
	input  bru_pkg::cmp_t               cmp_i,
	input  logic [bru_pkg::XLEN-1:0]    offs16_i,
	input  logic [bru_pkg::XLEN-1:0]    offs26_i,
	input  logic [bru_pkg::REG_W-1:0]   rj_idx_i,
	input  logic [bru_pkg::REG_W-1:0]   rd_idx_i,
	input  logic                        link_i,
	input  logic                        pred_taken_i,
	input  logic [bru_pkg::XLEN-1:0]    pred_target_i,
	output logic                        is_branch_o,
	output logic                        taken_o,
	output logic [bru_pkg::XLEN-1:0]    target_o,
	output logic                        mispredict_o,
	output bru_pkg::br_class_t          class_o,
	output logic [bru_pkg::XLEN-1:0]    link_pc_o
);

	logic [bru_pkg::XLEN-1:0] pc_next;

	assign pc_next     = pc_i + 32'd4;
	assign link_pc_o   = pc_next;
	assign is_branch_o = valid_i && kind_i != bru_pkg::BR_NONE;

	// ------------------------------------------------------------
	// Direction
	// ------------------------------------------------------------
	always_comb begin
		case (kind_i)
			bru_pkg::BR_COND: begin
				case (cmp_i)
					bru_pkg::CMP_EQ:  taken_o = rj_i == rd_i;
					bru_pkg::CMP_NE:  taken_o = rj_i != rd_i;
					bru_pkg::CMP_LT:  taken_o = $signed(rj_i) < $signed(rd_i);
					bru_pkg::CMP_GE:  taken_o = $signed(rj_i) >= $signed(rd_i);
					bru_pkg::CMP_LTU: taken_o = rj_i < rd_i;
					bru_pkg::CMP_GEU: taken_o = rj_i >= rd_i;
					default:          taken_o = 1'b0;
				endcase
			end
			bru_pkg::BR_IMM,
			bru_pkg::BR_IND: taken_o = 1'b1;
			default:         taken_o = 1'b0;
		endcase
	end

	// Target
	always_comb begin
		case (kind_i)
			bru_pkg::BR_IMM:  target_o = pc_i + offs26_i;
			bru_pkg::BR_IND:  target_o = rj_i + offs16_i;
			bru_pkg::BR_COND: target_o = taken_o ? pc_i + offs16_i : pc_next;
			default:          target_o = pc_next;
		endcase
	end

	// Wrong direction, or taken both ways to different places
	assign mispredict_o = (pred_taken_i != taken_o) ||
		(pred_taken_i && taken_o && pred_target_i != target_o);

	// ------------------------------------------------------------
	// Classification
	// ------------------------------------------------------------
	always_comb begin
		if ((kind_i == bru_pkg::BR_IND && rd_idx_i == bru_pkg::RA_INDEX) || link_i) begin
			class_o = bru_pkg::CLS_CALL;
		end else if (kind_i == bru_pkg::BR_IND && rj_idx_i == bru_pkg::RA_INDEX &&
			offs16_i == '0) begin
			class_o = bru_pkg::CLS_RETURN;
		end else if (kind_i == bru_pkg::BR_IMM || kind_i == bru_pkg::BR_IND) begin
			class_o = bru_pkg::CLS_ABSOLUTE;
		end else begin
			class_o = bru_pkg::CLS_RELATIVE;
		end
	end

	// Idle lanes come from issue with no kind and no prediction
	always_comb begin
		a_idle_miss: assert final (valid_i || !mispredict_o)
			else $error("mispredict on an idle lane");
	end

endmodule

// ==== bru_checker.sv ====
// Checks DUT outputs at negedge while chk_i is high; lane fields only for expected updates
`timescale 1ns/100ps

module bru_checker (
	input  logic                clk,
	input  logic                chk_i,
	input  int                  test_i,
	input  logic                exp_redirect_i,
	input  logic [31:0]         exp_redirect_pc_i,
	input  logic [1:0]          exp_upd_i,
	input  logic [1:0]          exp_taken_i,
	input  logic [1:0][31:0]    exp_target_i,
	input  logic [1:0][1:0]     exp_class_i,
	input  logic [1:0][31:0]    exp_link_i,
	input  logic [1:0][31:0]    exp_pc_i,
	input  logic                redirect_i,
	input  logic [31:0]         redirect_pc_i,
	input  logic [1:0]          upd_valid_i,
	input  logic [1:0][31:0]    upd_pc_i,
	input  logic [1:0]          upd_taken_i,
	input  logic [1:0][31:0]    upd_target_i,
	input  logic [1:0][1:0]     upd_class_i,
	input  logic [1:0][31:0]    link_i,
	output int                  pass_cnt_o,
	output int                  fail_cnt_o
);

	logic bad;

	initial begin
		pass_cnt_o = 0;
		fail_cnt_o = 0;
	end

	task automatic report(input string what, input logic [31:0] got, input logic [31:0] exp);
		$display("mismatch at time %0t: test %0d %s got %h expected %h",
			$time, test_i, what, got, exp);
		bad = 1'b1;
	endtask

	always @(negedge clk) begin
		if (chk_i) begin
			bad = 1'b0;
			if (redirect_i !== exp_redirect_i)
				report("redirect", 32'(redirect_i), 32'(exp_redirect_i));
			if (exp_redirect_i && redirect_pc_i !== exp_redirect_pc_i)
				report("redirect pc", redirect_pc_i, exp_redirect_pc_i);
			if (upd_valid_i !== exp_upd_i)
				report("update valid", 32'(upd_valid_i), 32'(exp_upd_i));
			for (int k = 0; k < 2; k++) begin
				if (exp_upd_i[k]) begin
					if (upd_pc_i[k] !== exp_pc_i[k])
						report("update pc", upd_pc_i[k], exp_pc_i[k]);
					if (upd_taken_i[k] !== exp_taken_i[k])
						report("taken", 32'(upd_taken_i[k]), 32'(exp_taken_i[k]));
					if (upd_target_i[k] !== exp_target_i[k])
						report("target", upd_target_i[k], exp_target_i[k]);
					if (upd_class_i[k] !== exp_class_i[k])
						report("class", 32'(upd_class_i[k]), 32'(exp_class_i[k]));
					if (link_i[k] !== exp_link_i[k])
						report("link", link_i[k], exp_link_i[k]);
				end
			end
			if (bad) begin
				fail_cnt_o = fail_cnt_o + 1;
				$display("test %0d: FAIL", test_i);
			end else begin
				pass_cnt_o = pass_cnt_o + 1;
				$display("test %0d: PASS", test_i);
			end
		end
	end

endmodule

// ==== bru_issue.sv ====
// Issue register for one group; flush beats stall, payload fields are not reset
`timescale 1ns/100ps

module bru_issue (
	input  logic                                           clk,
	input  logic                                           arst_n_i,
	input  logic                                           stall_i,
	input  logic                                           csr_flush_i,
	input  logic [bru_pkg::LANES-1:0]                      group_valid_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   pc_i,
	input  logic [bru_pkg::LANES-1:0][31:0]                inst_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   rj_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   rd_i,
	input  logic [bru_pkg::LANES-1:0]                      pred_taken_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   pred_target_i,
	output logic [bru_pkg::LANES-1:0]                      valid_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   pc_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   rj_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   rd_o,
	output bru_pkg::br_kind_t [bru_pkg::LANES-1:0]         kind_o,
	output bru_pkg::cmp_t [bru_pkg::LANES-1:0]             cmp_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   offs16_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   offs26_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::REG_W-1:0]  rj_idx_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::REG_W-1:0]  rd_idx_o,
	output logic [bru_pkg::LANES-1:0]                      link_o,
	output logic [bru_pkg::LANES-1:0]                      pred_taken_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   pred_target_o
);

	bru_pkg::br_kind_t [bru_pkg::LANES-1:0] kind_d;
	bru_pkg::cmp_t [bru_pkg::LANES-1:0]     cmp_d;

	// ------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------
	always_comb begin
		for (int k = 0; k < bru_pkg::LANES; k++) begin
			kind_d[k] = bru_pkg::BR_NONE;
			cmp_d[k]  = bru_pkg::CMP_NONE;
			case (bru_pkg::opcode_t'(inst_i[k][31:26]))
				bru_pkg::OP_JIRL: kind_d[k] = bru_pkg::BR_IND;
				bru_pkg::OP_B,
				bru_pkg::OP_BL:   kind_d[k] = bru_pkg::BR_IMM;
				bru_pkg::OP_BEQ:  cmp_d[k] = bru_pkg::CMP_EQ;
				bru_pkg::OP_BNE:  cmp_d[k] = bru_pkg::CMP_NE;
				bru_pkg::OP_BLT:  cmp_d[k] = bru_pkg::CMP_LT;
				bru_pkg::OP_BGE:  cmp_d[k] = bru_pkg::CMP_GE;
				bru_pkg::OP_BLTU: cmp_d[k] = bru_pkg::CMP_LTU;
				bru_pkg::OP_BGEU: cmp_d[k] = bru_pkg::CMP_GEU;
				default: ;
			endcase
			// Any compare means a conditional branch
			if (cmp_d[k] != bru_pkg::CMP_NONE) begin
				kind_d[k] = bru_pkg::BR_COND;
			end
		end
	end

	// ------------------------------------------------------------
	// Issue register
	// ------------------------------------------------------------
	// Idle lanes carry no kind and no prediction
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o      <= '0;
			pred_taken_o <= '0;
			for (int k = 0; k < bru_pkg::LANES; k++) begin
				kind_o[k] <= bru_pkg::BR_NONE;
			end
		end else if (csr_flush_i) begin
			valid_o      <= '0;
			pred_taken_o <= '0;
			for (int k = 0; k < bru_pkg::LANES; k++) begin
				kind_o[k] <= bru_pkg::BR_NONE;
			end
		end else if (!stall_i) begin
			valid_o      <= group_valid_i;
			pred_taken_o <= group_valid_i & pred_taken_i;
			for (int k = 0; k < bru_pkg::LANES; k++) begin
				kind_o[k] <= group_valid_i[k] ? kind_d[k] : bru_pkg::BR_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			for (int k = 0; k < bru_pkg::LANES; k++) begin
				pc_o[k]          <= pc_i[k];
				rj_o[k]          <= rj_i[k];
				rd_o[k]          <= rd_i[k];
				cmp_o[k]         <= cmp_d[k];
				// offs16 is inst[25:10], offs26 puts inst[9:0] on top
				offs16_o[k]      <= {{14{inst_i[k][25]}}, inst_i[k][25:10], 2'b00};
				offs26_o[k]      <= {{4{inst_i[k][9]}}, inst_i[k][9:0], inst_i[k][25:10], 2'b00};
				rj_idx_o[k]      <= inst_i[k][9:5];
				rd_idx_o[k]      <= inst_i[k][4:0];
				link_o[k]        <= inst_i[k][31:26] == bru_pkg::OP_BL;
				pred_target_o[k] <= pred_target_i[k];
			end
		end
	end

	for (genvar k = 0; k < bru_pkg::LANES; k++) begin : g_chk
		a_idle_kind: assert property (@(posedge clk) disable iff (!arst_n_i)
			!valid_o[k] |-> kind_o[k] == bru_pkg::BR_NONE)
			else $error("lane %0d idle with a branch kind", k);
	end

endmodule

// ==== bru_pkg.sv ====
// Shared widths and encodings; opcode values are the LA32R major field in bits 31..26
package bru_pkg;

	// ------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------
	localparam int LANES = 2;
	localparam int XLEN  = 32;
	localparam int REG_W = 5;

	// Link register r1
	localparam logic [REG_W-1:0] RA_INDEX = 5'd1;

	// ------------------------------------------------------------
	// Encodings
	// ------------------------------------------------------------
	// Branch major opcodes, anything else is not a branch
	typedef enum logic [5:0] {
		OP_JIRL = 6'b010011,
		OP_B    = 6'b010100,
		OP_BL   = 6'b010101,
		OP_BEQ  = 6'b010110,
		OP_BNE  = 6'b010111,
		OP_BLT  = 6'b011000,
		OP_BGE  = 6'b011001,
		OP_BLTU = 6'b011010,
		OP_BGEU = 6'b011011
	} opcode_t;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_IMM,   // b, bl with 26-bit offset
		BR_IND,   // jirl
		BR_COND
	} br_kind_t;

	typedef enum logic [2:0] {
		CMP_EQ,
		CMP_NE,
		CMP_LT,
		CMP_GE,
		CMP_LTU,
		CMP_GEU,
		CMP_NONE
	} cmp_t;

	// Predictor update class
	typedef enum logic [1:0] {
		CLS_RELATIVE,
		CLS_ABSOLUTE,
		CLS_CALL,
		CLS_RETURN
	} br_class_t;

endpackage

// ==== bru_redirect.sv ====
// Oldest-first redirect; CSR flush wins over stall, update pc is taken as link minus 4
`timescale 1ns/100ps

module bru_redirect (
	input  logic                                           clk,
	input  logic                                           arst_n_i,
	input  logic                                           stall_i,
	input  logic                                           csr_flush_i,
	input  logic [bru_pkg::XLEN-1:0]                       csr_target_i,
	input  logic [bru_pkg::LANES-1:0]                      valid_i,
	input  logic [bru_pkg::LANES-1:0]                      is_branch_i,
	input  logic [bru_pkg::LANES-1:0]                      taken_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   target_i,
	input  logic [bru_pkg::LANES-1:0]                      mispredict_i,
	input  bru_pkg::br_class_t [bru_pkg::LANES-1:0]        class_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   link_i,
	output logic                                           redirect_o,
	output logic [bru_pkg::XLEN-1:0]                       redirect_pc_o,
	output logic [bru_pkg::LANES-1:0]                      upd_valid_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   upd_pc_o,
	output logic [bru_pkg::LANES-1:0]                      upd_taken_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   upd_target_o,
	output bru_pkg::br_class_t [bru_pkg::LANES-1:0]        upd_class_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   link_o
);

	logic                             redirect_d;
	logic [bru_pkg::XLEN-1:0]         redirect_pc_d;
	logic [bru_pkg::LANES-1:0]        upd_valid_d;

	// ------------------------------------------------------------
	// Priority scan, lane 0 oldest
	// ------------------------------------------------------------
	always_comb begin
		logic older_miss;
		older_miss    = 1'b0;
		redirect_d    = 1'b0;
		redirect_pc_d = '0;
		for (int k = 0; k < bru_pkg::LANES; k++) begin
			upd_valid_d[k] = valid_i[k] && is_branch_i[k] && !older_miss;
			if (valid_i[k] && mispredict_i[k] && !older_miss) begin
				redirect_d    = 1'b1;
				redirect_pc_d = target_i[k];
			end
			older_miss = older_miss || (valid_i[k] && mispredict_i[k]);
		end
		if (csr_flush_i) begin
			redirect_d    = 1'b1;
			redirect_pc_d = csr_target_i;
			upd_valid_d   = '0;
		end else if (stall_i) begin
			redirect_d    = 1'b0;
			redirect_pc_d = '0;
			upd_valid_d   = '0;
		end
	end

	// ------------------------------------------------------------
	// Output registers
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			redirect_o  <= 1'b0;
			upd_valid_o <= '0;
		end else begin
			redirect_o  <= redirect_d;
			upd_valid_o <= upd_valid_d;
		end
	end

	always_ff @(posedge clk) begin
		redirect_pc_o <= redirect_pc_d;
		for (int k = 0; k < bru_pkg::LANES; k++) begin
			if (stall_i) begin
				upd_pc_o[k]     <= '0;
				upd_taken_o[k]  <= 1'b0;
				upd_target_o[k] <= '0;
				upd_class_o[k]  <= bru_pkg::CLS_RELATIVE;
				link_o[k]       <= '0;
			end else begin
				upd_pc_o[k]     <= link_i[k] - 32'd4;
				upd_taken_o[k]  <= taken_i[k];
				upd_target_o[k] <= target_i[k];
				upd_class_o[k]  <= class_i[k];
				link_o[k]       <= link_i[k];
			end
		end
	end

	// No update behind a mispredicting lane, one cycle later
	for (genvar j = 0; j < bru_pkg::LANES - 1; j++) begin : g_chk
		a_young_upd: assert property (@(posedge clk) disable iff (!arst_n_i)
			valid_i[j] && mispredict_i[j] |=> upd_valid_o[bru_pkg::LANES-1:j+1] == '0)
			else $error("update behind mispredicting lane %0d", j);
	end

endmodule

// ==== bru_stimulus.txt ====
# gv pred stall flush csr | pc0 inst0 rj0 rd0 ptgt0 | pc1 inst1 rj1 rd1 ptgt1
# | redir rpc upd taken tgt0 cls0 tgt1 cls1   (hex, pred/upd/taken bit0 is lane 0)
1 0 0 0 0 1000 58001000 5 5 0 1004 02800000 0 0 0 1 1010 1 1 1010 0 0 0
1 0 0 0 0 1000 58001000 5 6 0 1004 02800000 0 0 0 0 0 1 0 1004 0 0 0
1 1 0 0 0 1000 5c001000 5 6 1010 1004 02800000 0 0 0 0 0 1 1 1010 0 0 0
1 0 0 0 0 1000 60001000 ffffffff 1 0 1004 02800000 0 0 0 1 1010 1 1 1010 0 0 0
1 1 0 0 0 1000 68001000 ffffffff 1 1010 1004 02800000 0 0 0 1 1004 1 0 1004 0 0 0
1 0 0 0 0 1000 64001000 80000000 7fffffff 0 1004 02800000 0 0 0 0 0 1 0 1004 0 0 0
1 1 0 0 0 1000 6c001000 80000000 7fffffff 1010 1004 02800000 0 0 0 0 0 1 1 1010 0 0 0
1 0 0 0 0 1000 67fff000 80000000 80000000 0 1004 02800000 0 0 0 1 ff0 1 1 ff0 0 0 0
1 1 0 0 0 1000 68001000 0 1 2000 1004 02800000 0 0 0 1 1010 1 1 1010 0 0 0
1 1 0 0 0 1000 50010000 0 0 1100 1004 02800000 0 0 0 0 0 1 1 1100 1 0 0
1 0 0 0 0 1000 57ffffff 0 0 0 1004 02800000 0 0 0 1 ffc 1 1 ffc 2 0 0
1 1 0 0 0 1000 4c000841 8000 0 8008 1004 02800000 0 0 0 0 0 1 1 8008 2 0 0
1 1 0 0 0 1000 4c000020 3000 0 3000 1004 02800000 0 0 0 0 0 1 1 3000 3 0 0
1 1 0 0 0 1000 4c000420 3000 0 3000 1004 02800000 0 0 0 1 3004 1 1 3004 1 0 0
3 0 0 0 0 1000 58001000 7 7 0 1004 5c001000 1 2 0 1 1010 1 1 1010 0 0 0
3 0 0 0 0 1000 58001000 1 2 0 1004 5c001000 1 2 0 1 1014 3 2 1004 0 1014 0
1 1 0 0 0 1000 02800000 0 0 5000 1004 02800000 0 0 0 1 1004 0 0 0 0 0 0
1 0 0 1 80000000 1000 58001000 7 7 0 1004 02800000 0 0 0 1 80000000 0 0 0 0 0 0
1 0 4 0 0 1000 60001000 1 2 0 1004 02800000 0 0 0 1 1010 1 1 1010 0 0 0

// ==== bru_top.sv ====
// Branch feedback stage top; one cycle from issue capture to registered redirect
`timescale 1ns/100ps

module bru_top (
	input  logic                                           clk,
	input  logic                                           arst_n_i,
	input  logic [bru_pkg::LANES-1:0]                      group_valid_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   pc_i,
	input  logic [bru_pkg::LANES-1:0][31:0]                inst_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   rj_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   rd_i,
	input  logic [bru_pkg::LANES-1:0]                      pred_taken_i,
	input  logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   pred_target_i,
	input  logic                                           stall_i,
	input  logic                                           csr_flush_i,
	input  logic [bru_pkg::XLEN-1:0]                       csr_target_i,
	output logic                                           redirect_o,
	output logic [bru_pkg::XLEN-1:0]                       redirect_pc_o,
	output logic [bru_pkg::LANES-1:0]                      upd_valid_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   upd_pc_o,
	output logic [bru_pkg::LANES-1:0]                      upd_taken_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   upd_target_o,
	output bru_pkg::br_class_t [bru_pkg::LANES-1:0]        upd_class_o,
	output logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   link_o
);

	// Issue register outputs
	logic [bru_pkg::LANES-1:0]                      iss_valid;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   iss_pc;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   iss_rj;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   iss_rd;
	bru_pkg::br_kind_t [bru_pkg::LANES-1:0]         iss_kind;
	bru_pkg::cmp_t [bru_pkg::LANES-1:0]             iss_cmp;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   iss_offs16;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   iss_offs26;
	logic [bru_pkg::LANES-1:0][bru_pkg::REG_W-1:0]  iss_rj_idx;
	logic [bru_pkg::LANES-1:0][bru_pkg::REG_W-1:0]  iss_rd_idx;
	logic [bru_pkg::LANES-1:0]                      iss_link;
	logic [bru_pkg::LANES-1:0]                      iss_pred_taken;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   iss_pred_target;

	// Lane results
	logic [bru_pkg::LANES-1:0]                      res_is_branch;
	logic [bru_pkg::LANES-1:0]                      res_taken;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   res_target;
	logic [bru_pkg::LANES-1:0]                      res_mispredict;
	bru_pkg::br_class_t [bru_pkg::LANES-1:0]        res_class;
	logic [bru_pkg::LANES-1:0][bru_pkg::XLEN-1:0]   res_link;

	bru_issue u_issue (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.stall_i       (stall_i),
		.csr_flush_i   (csr_flush_i),
		.group_valid_i (group_valid_i),
		.pc_i          (pc_i),
		.inst_i        (inst_i),
		.rj_i          (rj_i),
		.rd_i          (rd_i),
		.pred_taken_i  (pred_taken_i),
		.pred_target_i (pred_target_i),
		.valid_o       (iss_valid),
		.pc_o          (iss_pc),
		.rj_o          (iss_rj),
		.rd_o          (iss_rd),
		.kind_o        (iss_kind),
		.cmp_o         (iss_cmp),
		.offs16_o      (iss_offs16),
		.offs26_o      (iss_offs26),
		.rj_idx_o      (iss_rj_idx),
		.rd_idx_o      (iss_rd_idx),
		.link_o        (iss_link),
		.pred_taken_o  (iss_pred_taken),
		.pred_target_o (iss_pred_target)
	);

	for (genvar k = 0; k < bru_pkg::LANES; k++) begin : g_lane
		branch_resolve u_resolve (
			.valid_i       (iss_valid[k]),
			.pc_i          (iss_pc[k]),
			.rj_i          (iss_rj[k]),
			.rd_i          (iss_rd[k]),
			.kind_i        (iss_kind[k]),
			.cmp_i         (iss_cmp[k]),
			.offs16_i      (iss_offs16[k]),
			.offs26_i      (iss_offs26[k]),
			.rj_idx_i      (iss_rj_idx[k]),
			.rd_idx_i      (iss_rd_idx[k]),
			.link_i        (iss_link[k]),
			.pred_taken_i  (iss_pred_taken[k]),
			.pred_target_i (iss_pred_target[k]),
			.is_branch_o   (res_is_branch[k]),
			.taken_o       (res_taken[k]),
			.target_o      (res_target[k]),
			.mispredict_o  (res_mispredict[k]),
			.class_o       (res_class[k]),
			.link_pc_o     (res_link[k])
		);
	end

	bru_redirect u_redirect (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.stall_i       (stall_i),
		.csr_flush_i   (csr_flush_i),
		.csr_target_i  (csr_target_i),
		.valid_i       (iss_valid),
		.is_branch_i   (res_is_branch),
		.taken_i       (res_taken),
		.target_i      (res_target),
		.mispredict_i  (res_mispredict),
		.class_i       (res_class),
		.link_i        (res_link),
		.redirect_o    (redirect_o),
		.redirect_pc_o (redirect_pc_o),
		.upd_valid_o   (upd_valid_o),
		.upd_pc_o      (upd_pc_o),
		.upd_taken_o   (upd_taken_o),
		.upd_target_o  (upd_target_o),
		.upd_class_o   (upd_class_o),
		.link_o        (link_o)
	);

endmodule

// ==== files.f ====
bru_pkg.sv
bru_issue.sv
branch_resolve.sv
bru_redirect.sv
bru_top.sv
bru_checker.sv
tb_bru.sv

// ==== run.sh ====
#!/bin/bash
# Build and run with Verilator, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module tb_bru -o sim > build.log 2>&1 \
	&& ./obj_dir/sim > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0

// ==== tb_bru.sv ====
// Two-lane testbench; every stimulus line holds 23 hex columns, stall holds after capture
`timescale 1ns/100ps

module tb_bru;

	localparam int NCOL = 23;

	logic                clk = 1'b0;
	logic                arst_n_i;
	logic [1:0]          group_valid_i;
	logic [1:0][31:0]    pc_i;
	logic [1:0][31:0]    inst_i;
	logic [1:0][31:0]    rj_i;
	logic [1:0][31:0]    rd_i;
	logic [1:0]          pred_taken_i;
	logic [1:0][31:0]    pred_target_i;
	logic                stall_i;
	logic                csr_flush_i;
	logic [31:0]         csr_target_i;
	logic                redirect_o;
	logic [31:0]         redirect_pc_o;
	logic [1:0]          upd_valid_o;
	logic [1:0][31:0]    upd_pc_o;
	logic [1:0]          upd_taken_o;
	logic [1:0][31:0]    upd_target_o;
	bru_pkg::br_class_t [1:0] upd_class_o;
	logic [1:0][31:0]    link_o;

	// Expected values towards the checker
	logic                chk;
	int                  test_no;
	logic                exp_redirect;
	logic [31:0]         exp_rpc;
	logic [1:0]          exp_upd;
	logic [1:0]          exp_taken;
	logic [1:0][31:0]    exp_target;
	logic [1:0][1:0]     exp_class;
	logic [1:0][31:0]    exp_link;
	logic [1:0][31:0]    exp_pc;
	int                  pass_cnt;
	int                  fail_cnt;

	logic [31:0]         stim[$];
	logic                load_ok;
	int                  ntests;
	int                  seed = 32'h7f84;
	int                  cycles = 0;
	int                  limit = 100000;

	always #5 clk = ~clk;

	bru_top DUT (
		.clk(clk), .arst_n_i(arst_n_i), .group_valid_i(group_valid_i), .pc_i(pc_i),
		.inst_i(inst_i), .rj_i(rj_i), .rd_i(rd_i), .pred_taken_i(pred_taken_i),
		.pred_target_i(pred_target_i), .stall_i(stall_i), .csr_flush_i(csr_flush_i),
		.csr_target_i(csr_target_i), .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o),
		.upd_valid_o(upd_valid_o), .upd_pc_o(upd_pc_o), .upd_taken_o(upd_taken_o),
		.upd_target_o(upd_target_o), .upd_class_o(upd_class_o), .link_o(link_o)
	);

	bru_checker u_check (
		.clk(clk), .chk_i(chk), .test_i(test_no), .exp_redirect_i(exp_redirect),
		.exp_redirect_pc_i(exp_rpc), .exp_upd_i(exp_upd), .exp_taken_i(exp_taken),
		.exp_target_i(exp_target), .exp_class_i(exp_class), .exp_link_i(exp_link),
		.exp_pc_i(exp_pc), .redirect_i(redirect_o), .redirect_pc_i(redirect_pc_o),
		.upd_valid_i(upd_valid_o), .upd_pc_i(upd_pc_o), .upd_taken_i(upd_taken_o),
		.upd_target_i(upd_target_o), .upd_class_i(upd_class_o),
		.link_i(link_o), .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt)
	);

	// ------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] col(input int t, input int c);
		return stim[t * NCOL + c];
	endfunction

	task automatic drive_test(input int t);
		group_valid_i = 2'(col(t, 0));
		pred_taken_i  = 2'(col(t, 1));
		stall_i       = 1'b0;
		csr_flush_i   = 1'b0;
		for (int k = 0; k < 2; k++) begin
			pc_i[k]          = col(t, 5 + 5 * k);
			inst_i[k]        = col(t, 6 + 5 * k);
			rj_i[k]          = col(t, 7 + 5 * k);
			rd_i[k]          = col(t, 8 + 5 * k);
			pred_target_i[k] = col(t, 9 + 5 * k);
		end
	endtask

	// Idle lanes: non-branch, no prediction, random operands
	task automatic drive_idle(input logic stall, input logic flush, input logic [31:0] csr);
		group_valid_i = 2'b00;
		pred_taken_i  = 2'b00;
		stall_i       = stall;
		csr_flush_i   = flush;
		csr_target_i  = csr;
		for (int k = 0; k < 2; k++) begin
			inst_i[k]        = 32'h0280_0000;
			rj_i[k]          = $random(seed);
			rd_i[k]          = $random(seed);
			pred_target_i[k] = '0;
		end
	endtask

	task automatic set_expect(input int t, input logic zero);
		test_no      = t + 1;
		exp_redirect = zero ? 1'b0 : 1'(col(t, 15));
		exp_rpc      = col(t, 16);
		exp_upd      = zero ? 2'b00 : 2'(col(t, 17));
		exp_taken    = 2'(col(t, 18));
		for (int k = 0; k < 2; k++) begin
			exp_target[k] = col(t, 19 + 2 * k);
			exp_class[k]  = 2'(col(t, 20 + 2 * k));
			exp_link[k]   = col(t, 5 + 5 * k) + 32'd4;
			exp_pc[k]     = col(t, 5 + 5 * k);
		end
	endtask

	task automatic load_stimulus(output logic ok);
		int          fd;
		int          n;
		int          line_no;
		string       line;
		logic [31:0] v[NCOL];
		ok = 1'b1;
		fd = $fopen("bru_stimulus.txt", "r");
		if (fd == 0) begin
			$display("stimulus file bru_stimulus.txt could not be opened");
			ok = 1'b0;
		end else begin
			line_no = 0;
			while (ok && $fgets(line, fd)) begin
				line_no++;
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
					v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21], v[22]);
				if (n != NCOL) begin
					$display("stimulus line %0d is malformed, %0d columns read", line_no, n);
					ok = 1'b0;
				end else begin
					for (int c = 0; c < NCOL; c++)
						stim.push_back(v[c]);
				end
			end
			$fclose(fd);
			if (ok && stim.size() == 0) begin
				$display("stimulus file bru_stimulus.txt holds no tests");
				ok = 1'b0;
			end
		end
	endtask

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, the run exceeded %0d cycles", limit);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		arst_n_i     = 1'b0;
		chk          = 1'b0;
		test_no      = 0;
		exp_redirect = 1'b0;
		exp_rpc      = '0;
		exp_upd      = '0;
		exp_taken    = '0;
		exp_target   = '0;
		exp_class    = '0;
		exp_link     = '0;
		exp_pc       = '0;
		drive_idle(1'b0, 1'b0, '0);
		pc_i = '0;
		load_stimulus(load_ok);
		if (!load_ok) begin
			$display("tests failed");
			$finish;
		end else begin
			ntests = stim.size() / NCOL;
			limit  = 4 * ntests + 50;
			repeat (5) @(posedge clk);
			#1 arst_n_i = 1'b1;
			for (int t = 0; t < ntests; t++) begin
				drive_test(t);
				@(posedge clk);
				#1 chk = 1'b0;
				if (col(t, 2) != 0) begin
					drive_idle(1'b1, 1'b0, '0);
					repeat (col(t, 2)) @(posedge clk);
					#1 set_expect(t, 1'b1);
					chk     = 1'b1;
					stall_i = 1'b0;
					@(negedge clk);
					#1 chk = 1'b0;
				end else begin
					drive_idle(1'b0, 1'(col(t, 3)), col(t, 4));
				end
				@(posedge clk);
				#1 set_expect(t, 1'b0);
				chk = 1'b1;
			end
			drive_idle(1'b0, 1'b0, '0);
			@(negedge clk);
			#1 chk = 1'b0;
			$display("summary: %0d passed, %0d with errors", pass_cnt, fail_cnt);
			if (fail_cnt == 0 && pass_cnt > 0) begin
				$display("all tests passed");
			end else begin
				$display("tests failed");
			end
			$finish;
		end
	end

endmodule
